/* cpuTypesPkg.sv */
`default_nettype none

package cpuTypesPkg;

  // Basic widths
  typedef logic [31:0] word_t;
  typedef logic [4:0] regbits_t;

  // Opcodes of the supported subset
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_JAL   = 6'h03,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDIU = 6'h09,
    OP_SLTI  = 6'h0a,
    OP_ANDI  = 6'h0c,
    OP_ORI   = 6'h0d,
    OP_XORI  = 6'h0e,
    OP_LUI   = 6'h0f,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b,
    OP_HALT  = 6'h3f
  } opcode_t;

  // R-type function field
  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_SRL  = 6'h02,
    FN_JR   = 6'h08,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_NOR  = 6'h27,
    FN_SLT  = 6'h2a,
    FN_SLTU = 6'h2b
  } funct_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_NOR, ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL
  } aluOp_t;

  // Three views of one instruction word
  typedef struct packed {
    opcode_t opcode;
    regbits_t rs;
    regbits_t rt;
    regbits_t rd;
    logic [4:0] shamt;
    funct_t funct;
  } rType_t;

  typedef struct packed {
    opcode_t opcode;
    regbits_t rs;
    regbits_t rt;
    logic [15:0] imm;
  } iType_t;

  typedef struct packed {
    opcode_t opcode;
    logic [25:0] target;
  } jType_t;

  typedef union packed {
    rType_t rType;
    iType_t iType;
    jType_t jType;
  } instr_t;

  // Register write-back source
  typedef enum logic [1:0] {WB_ALU, WB_NPC, WB_LOAD, WB_LUI} wbSel_t;

  // Next PC source; sequential also covers branches
  typedef enum logic [1:0] {PC_SEQ, PC_JUMP, PC_REG} pcSel_t;

  typedef struct packed {
    aluOp_t aluOp;
    logic aluSrc;
    logic extOp;
    logic regDst;
    logic regWr;
    logic jal;
    logic beq;
    logic bne;
    wbSel_t wbSel;
    pcSel_t pcSel;
    logic dRen;
    logic dWen;
    logic halt;
  } ctrl_t;

  // Memory port
  typedef struct packed {
    logic ren;
    logic wen;
    word_t addr;
    word_t store;
  } memReq_t;

  typedef struct packed {
    logic ready;
    word_t load;
  } memResp_t;

  localparam word_t PC_INIT = 32'h0000_0000;
  localparam regbits_t LINK_REG = 5'd31;

endpackage

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  cpuTypesPkg::aluOp_t aluOp,
  input  cpuTypesPkg::word_t  portA,
  input  cpuTypesPkg::word_t  portB,
  input  logic [4:0]          shamt,
  output cpuTypesPkg::word_t  result,
  output logic                zero
);

  always_comb begin
    case (aluOp)
      cpuTypesPkg::ALU_ADD:  result = portA + portB;
      cpuTypesPkg::ALU_SUB:  result = portA - portB;
      cpuTypesPkg::ALU_AND:  result = portA & portB;
      cpuTypesPkg::ALU_OR:   result = portA | portB;
      cpuTypesPkg::ALU_XOR:  result = portA ^ portB;
      cpuTypesPkg::ALU_NOR:  result = ~(portA | portB);
      // Signed compare
      cpuTypesPkg::ALU_SLT:  result = {31'd0, $signed(portA) < $signed(portB)};
      cpuTypesPkg::ALU_SLTU: result = {31'd0, portA < portB};
      // Shifts act on the second operand
      cpuTypesPkg::ALU_SLL:  result = portB << shamt;
      cpuTypesPkg::ALU_SRL:  result = portB >> shamt;
      default:               result = '0;
    endcase
  end

  // Used by BEQ and BNE
  assign zero = (result == '0);

endmodule

`default_nettype wire

/* controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
  input  cpuTypesPkg::instr_t instr,
  output cpuTypesPkg::ctrl_t  ctrl
);

  always_comb begin
    // Everything off unless the opcode says otherwise
    ctrl.aluOp  = cpuTypesPkg::ALU_ADD;
    ctrl.aluSrc = 1'b0;
    ctrl.extOp  = 1'b0;
    ctrl.regDst = 1'b0;
    ctrl.regWr  = 1'b0;
    ctrl.jal    = 1'b0;
    ctrl.beq    = 1'b0;
    ctrl.bne    = 1'b0;
    ctrl.wbSel  = cpuTypesPkg::WB_ALU;
    ctrl.pcSel  = cpuTypesPkg::PC_SEQ;
    ctrl.dRen   = 1'b0;
    ctrl.dWen   = 1'b0;
    ctrl.halt   = 1'b0;

    case (instr.iType.opcode)
      cpuTypesPkg::OP_RTYPE: begin
        ctrl.regDst = 1'b1;
        ctrl.regWr  = 1'b1;
        case (instr.rType.funct)
          cpuTypesPkg::FN_ADDU: ctrl.aluOp = cpuTypesPkg::ALU_ADD;
          cpuTypesPkg::FN_SUBU: ctrl.aluOp = cpuTypesPkg::ALU_SUB;
          cpuTypesPkg::FN_AND:  ctrl.aluOp = cpuTypesPkg::ALU_AND;
          cpuTypesPkg::FN_OR:   ctrl.aluOp = cpuTypesPkg::ALU_OR;
          cpuTypesPkg::FN_XOR:  ctrl.aluOp = cpuTypesPkg::ALU_XOR;
          cpuTypesPkg::FN_NOR:  ctrl.aluOp = cpuTypesPkg::ALU_NOR;
          cpuTypesPkg::FN_SLT:  ctrl.aluOp = cpuTypesPkg::ALU_SLT;
          cpuTypesPkg::FN_SLTU: ctrl.aluOp = cpuTypesPkg::ALU_SLTU;
          cpuTypesPkg::FN_SLL:  ctrl.aluOp = cpuTypesPkg::ALU_SLL;
          cpuTypesPkg::FN_SRL:  ctrl.aluOp = cpuTypesPkg::ALU_SRL;
          cpuTypesPkg::FN_JR: begin
            // Register jump, nothing written back
            ctrl.regWr = 1'b0;
            ctrl.pcSel = cpuTypesPkg::PC_REG;
          end
          default: ctrl.regWr = 1'b0;
        endcase
      end
      // Immediate arithmetic sign extends
      cpuTypesPkg::OP_ADDIU: begin
        ctrl.aluSrc = 1'b1;
        ctrl.extOp  = 1'b1;
        ctrl.regWr  = 1'b1;
      end
      cpuTypesPkg::OP_SLTI: begin
        ctrl.aluOp  = cpuTypesPkg::ALU_SLT;
        ctrl.aluSrc = 1'b1;
        ctrl.extOp  = 1'b1;
        ctrl.regWr  = 1'b1;
      end
      // Logic immediates zero extend
      cpuTypesPkg::OP_ANDI: begin
        ctrl.aluOp  = cpuTypesPkg::ALU_AND;
        ctrl.aluSrc = 1'b1;
        ctrl.regWr  = 1'b1;
      end
      cpuTypesPkg::OP_ORI: begin
        ctrl.aluOp  = cpuTypesPkg::ALU_OR;
        ctrl.aluSrc = 1'b1;
        ctrl.regWr  = 1'b1;
      end
      cpuTypesPkg::OP_XORI: begin
        ctrl.aluOp  = cpuTypesPkg::ALU_XOR;
        ctrl.aluSrc = 1'b1;
        ctrl.regWr  = 1'b1;
      end
      cpuTypesPkg::OP_LUI: begin
        ctrl.regWr = 1'b1;
        ctrl.wbSel = cpuTypesPkg::WB_LUI;
      end
      // Address is base plus signed offset
      cpuTypesPkg::OP_LW: begin
        ctrl.aluSrc = 1'b1;
        ctrl.extOp  = 1'b1;
        ctrl.regWr  = 1'b1;
        ctrl.wbSel  = cpuTypesPkg::WB_LOAD;
        ctrl.dRen   = 1'b1;
      end
      cpuTypesPkg::OP_SW: begin
        ctrl.aluSrc = 1'b1;
        ctrl.extOp  = 1'b1;
        ctrl.dWen   = 1'b1;
      end
      // Compare by subtraction, zero flag decides
      cpuTypesPkg::OP_BEQ: begin
        ctrl.aluOp = cpuTypesPkg::ALU_SUB;
        ctrl.beq   = 1'b1;
      end
      cpuTypesPkg::OP_BNE: begin
        ctrl.aluOp = cpuTypesPkg::ALU_SUB;
        ctrl.bne   = 1'b1;
      end
      cpuTypesPkg::OP_J: ctrl.pcSel = cpuTypesPkg::PC_JUMP;
      cpuTypesPkg::OP_JAL: begin
        ctrl.pcSel = cpuTypesPkg::PC_JUMP;
        ctrl.jal   = 1'b1;
        ctrl.regWr = 1'b1;
        ctrl.wbSel = cpuTypesPkg::WB_NPC;
      end
      cpuTypesPkg::OP_HALT: ctrl.halt = 1'b1;
      // Unknown opcode acts as a no-op
      default: ctrl.regWr = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  wen,
  input  cpuTypesPkg::regbits_t wsel,
  input  cpuTypesPkg::regbits_t rsel1,
  input  cpuTypesPkg::regbits_t rsel2,
  input  cpuTypesPkg::word_t    wdat,
  output cpuTypesPkg::word_t    rdat1,
  output cpuTypesPkg::word_t    rdat2
);

  cpuTypesPkg::word_t regs [32];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      regs <= '{default: '0};
    end else if (wen && (wsel != 5'd0)) begin
      // Register zero never changes
      regs[wsel] <= wdat;
    end
  end

  // Plain reads, a write shows up next cycle
  assign rdat1 = regs[rsel1];
  assign rdat2 = regs[rsel2];

endmodule

`default_nettype wire

/* programCounter.sv */
`timescale 1ns/1ps
`default_nettype none

module programCounter (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                en,
  input  cpuTypesPkg::pcSel_t pcSel,
  input  logic                takeBranch,
  input  cpuTypesPkg::word_t  branchOff,
  input  cpuTypesPkg::word_t  jumpTarget,
  input  cpuTypesPkg::word_t  regTarget,
  output cpuTypesPkg::word_t  pc,
  output cpuTypesPkg::word_t  npc
);

  cpuTypesPkg::word_t nextPc;

  assign npc = pc + 32'd4;

  always_comb begin
    case (pcSel)
      // Branch offset is relative to the following instruction
      cpuTypesPkg::PC_SEQ:  nextPc = takeBranch ? npc + branchOff : npc;
      cpuTypesPkg::PC_JUMP: nextPc = jumpTarget;
      cpuTypesPkg::PC_REG:  nextPc = regTarget;
      default:              nextPc = npc;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= cpuTypesPkg::PC_INIT;
    end else if (en) begin
      pc <= nextPc;
    end
  end

endmodule

`default_nettype wire

/* requestUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module requestUnit (
  input  logic CLK,
  input  logic nRST,
  input  logic ihit,
  input  logic dhit,
  input  logic dRenReq,
  input  logic dWenReq,
  output logic dRen,
  output logic dWen
);

  // One data access in flight at most
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      dRen <= 1'b0;
      dWen <= 1'b0;
    end else if (dhit) begin
      // Access done, drop the request
      dRen <= 1'b0;
      dWen <= 1'b0;
    end else if (ihit) begin
      // Latch what the fetched instruction asks for
      dRen <= dRenReq;
      dWen <= dWenReq;
    end
  end

endmodule

`default_nettype wire

/* datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 ihit,
  input  logic                 dhit,
  input  cpuTypesPkg::word_t   imemLoad,
  input  cpuTypesPkg::word_t   dmemLoad,
  output logic                 iRen,
  output cpuTypesPkg::word_t   iAddr,
  output cpuTypesPkg::memReq_t dReq,
  output logic                 halt
);

  cpuTypesPkg::instr_t instr;
  cpuTypesPkg::ctrl_t ctrl;
  cpuTypesPkg::word_t signExtImm;
  cpuTypesPkg::word_t zeroExtImm;
  cpuTypesPkg::word_t aluPortB;
  cpuTypesPkg::word_t aluResult;
  cpuTypesPkg::word_t rdat1;
  cpuTypesPkg::word_t rdat2;
  cpuTypesPkg::word_t pc;
  cpuTypesPkg::word_t npc;
  cpuTypesPkg::word_t jumpTarget;
  cpuTypesPkg::word_t branchOff;
  cpuTypesPkg::word_t wdat;
  cpuTypesPkg::word_t dAddrHeld;
  cpuTypesPkg::word_t dStoreHeld;
  cpuTypesPkg::regbits_t wsel;
  cpuTypesPkg::regbits_t loadDest;
  logic aluZero;
  logic takeBranch;
  logic regWen;
  logic dRen;
  logic dWen;

  // Fetched word, only meaningful in the ihit cycle
  assign instr = imemLoad;

  controlUnit ctrlUnit0 (
    .instr(instr),
    .ctrl (ctrl)
  );

  // Immediates and targets
  assign signExtImm = {{16{instr.iType.imm[15]}}, instr.iType.imm};
  assign zeroExtImm = {16'h0000, instr.iType.imm};
  assign branchOff  = {signExtImm[29:0], 2'b00};
  assign jumpTarget = {npc[31:28], instr.jType.target, 2'b00};
  assign aluPortB   = !ctrl.aluSrc ? rdat2 : (ctrl.extOp ? signExtImm : zeroExtImm);

  alu alu0 (
    .aluOp (ctrl.aluOp),
    .portA (rdat1),
    .portB (aluPortB),
    .shamt (instr.rType.shamt),
    .result(aluResult),
    .zero  (aluZero)
  );

  assign takeBranch = (ctrl.beq & aluZero) | (ctrl.bne & ~aluZero);

  programCounter pc0 (
    .CLK       (CLK),
    .nRST      (nRST),
    .en        (ihit),
    .pcSel     (ctrl.pcSel),
    .takeBranch(takeBranch),
    .branchOff (branchOff),
    .jumpTarget(jumpTarget),
    .regTarget (rdat1),
    .pc        (pc),
    .npc       (npc)
  );

  // Loads write on dhit, everything else on ihit
  assign regWen = (ihit & ctrl.regWr & ~ctrl.dRen) | (dhit & dRen);

  always_comb begin
    if (dhit) begin
      // Fetched word is stale here, use the saved destination
      wsel = loadDest;
      wdat = dmemLoad;
    end else begin
      if (ctrl.jal) begin
        wsel = cpuTypesPkg::LINK_REG;
      end else if (ctrl.regDst) begin
        wsel = instr.rType.rd;
      end else begin
        wsel = instr.iType.rt;
      end
      case (ctrl.wbSel)
        cpuTypesPkg::WB_ALU:  wdat = aluResult;
        cpuTypesPkg::WB_NPC:  wdat = npc;
        cpuTypesPkg::WB_LOAD: wdat = dmemLoad;
        cpuTypesPkg::WB_LUI:  wdat = {instr.iType.imm, 16'h0000};
        default:              wdat = aluResult;
      endcase
    end
  end

  registerFile regFile0 (
    .CLK  (CLK),
    .nRST (nRST),
    .wen  (regWen),
    .wsel (wsel),
    .rsel1(instr.iType.rs),
    .rsel2(instr.iType.rt),
    .wdat (wdat),
    .rdat1(rdat1),
    .rdat2(rdat2)
  );

  requestUnit reqUnit0 (
    .CLK    (CLK),
    .nRST   (nRST),
    .ihit   (ihit),
    .dhit   (dhit),
    .dRenReq(ctrl.dRen),
    .dWenReq(ctrl.dWen),
    .dRen   (dRen),
    .dWen   (dWen)
  );

  // Data access payload, frozen until the access completes
  always_ff @(posedge CLK) begin
    if (ihit) begin
      dAddrHeld  <= aluResult;
      dStoreHeld <= rdat2;
      loadDest   <= instr.iType.rt;
    end
  end

  assign dReq.ren   = dRen;
  assign dReq.wen   = dWen;
  assign dReq.addr  = dAddrHeld;
  assign dReq.store = dStoreHeld;

  // Sticky halt, cleared only by reset
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else if (ihit && ctrl.halt) begin
      halt <= 1'b1;
    end
  end

  // No fetch once halted
  assign iRen  = ~halt;
  assign iAddr = pc;

endmodule

`default_nettype wire

/* memoryControl.sv */
`timescale 1ns/1ps
`default_nettype none

module memoryControl (
  input  logic                  iRen,
  input  cpuTypesPkg::word_t    iAddr,
  input  cpuTypesPkg::memReq_t  dReq,
  input  cpuTypesPkg::memResp_t memResp,
  output cpuTypesPkg::memReq_t  memReq,
  output logic                  ihit,
  output logic                  dhit,
  output cpuTypesPkg::word_t    loadData
);

  logic dPending;

  assign dPending = dReq.ren | dReq.wen;

  always_comb begin
    if (dPending) begin
      // Data side owns the port, fetch waits
      memReq = dReq;
      dhit   = memResp.ready;
      ihit   = 1'b0;
    end else begin
      memReq.ren   = iRen;
      memReq.wen   = 1'b0;
      memReq.addr  = iAddr;
      memReq.store = '0;
      dhit         = 1'b0;
      ihit         = iRen & memResp.ready;
    end
  end

  // Same read data serves both sides
  assign loadData = memResp.load;

endmodule

`default_nettype wire

/* singleCycleCpu.sv */
`timescale 1ns/1ps
`default_nettype none

module singleCycleCpu (
  input  logic                  CLK,
  input  logic                  nRST,
  output cpuTypesPkg::memReq_t  memReq,
  input  cpuTypesPkg::memResp_t memResp,
  output logic                  halt
);

  logic ihit;
  logic dhit;
  logic iRen;
  cpuTypesPkg::word_t iAddr;
  cpuTypesPkg::word_t loadData;
  cpuTypesPkg::memReq_t dReq;

  datapath dp0 (
    .CLK     (CLK),
    .nRST    (nRST),
    .ihit    (ihit),
    .dhit    (dhit),
    .imemLoad(loadData),
    .dmemLoad(loadData),
    .iRen    (iRen),
    .iAddr   (iAddr),
    .dReq    (dReq),
    .halt    (halt)
  );

  memoryControl memCtrl0 (
    .iRen    (iRen),
    .iAddr   (iAddr),
    .dReq    (dReq),
    .memResp (memResp),
    .memReq  (memReq),
    .ihit    (ihit),
    .dhit    (dhit),
    .loadData(loadData)
  );

endmodule

`default_nettype wire

/* tbChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module tbChecker (
  input  logic                  CLK,
  input  logic                  nRST,
  input  cpuTypesPkg::memReq_t  memReq,
  input  cpuTypesPkg::memResp_t memResp,
  input  logic                  halt,
  input  logic [255:0][31:0]    image,
  input  logic                  runDone,
  output int                    errorCount,
  output int                    storeCount,
  output logic                  checkDone
);

  // Private memory copy for the reference run
  logic [31:0] refMem [256];
  // Expected stores, in program order
  logic [31:0] expAddr [$];
  logic [31:0] expData [$];
  cpuTypesPkg::memReq_t prevReq;
  logic prevPending;
  logic prevReady;
  logic refReady = 1'b0;
  logic afterReset;
  int refSteps;
  int i;

  // Instruction-set reference, one instruction per loop pass until HALT
  function automatic int runReference();
    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] se;
    logic [31:0] ze;
    logic [31:0] ea;
    logic [31:0] wv;
    logic [4:0] wr;
    logic we;
    int n;
    int steps;
    for (n = 0; n < 32; n++) begin
      regs[n] = '0;
    end
    pc = cpuTypesPkg::PC_INIT;
    steps = 0;
    while (steps < 5000) begin
      ins = refMem[pc[9:2]];
      a = regs[ins[25:21]];
      b = regs[ins[20:16]];
      se = {{16{ins[15]}}, ins[15:0]};
      ze = {16'h0000, ins[15:0]};
      ea = a + se;
      wr = ins[20:16];
      we = 1'b1;
      wv = '0;
      steps++;
      // No delay slot, pc now holds the next address
      pc = pc + 32'd4;
      case (ins[31:26])
        cpuTypesPkg::OP_RTYPE: begin
          wr = ins[15:11];
          case (ins[5:0])
            cpuTypesPkg::FN_ADDU: wv = a + b;
            cpuTypesPkg::FN_SUBU: wv = a - b;
            cpuTypesPkg::FN_AND:  wv = a & b;
            cpuTypesPkg::FN_OR:   wv = a | b;
            cpuTypesPkg::FN_XOR:  wv = a ^ b;
            cpuTypesPkg::FN_NOR:  wv = ~(a | b);
            cpuTypesPkg::FN_SLT:  wv = {31'd0, $signed(a) < $signed(b)};
            cpuTypesPkg::FN_SLTU: wv = {31'd0, a < b};
            cpuTypesPkg::FN_SLL:  wv = b << ins[10:6];
            cpuTypesPkg::FN_SRL:  wv = b >> ins[10:6];
            cpuTypesPkg::FN_JR: begin
              we = 1'b0;
              pc = a;
            end
            default: we = 1'b0;
          endcase
        end
        cpuTypesPkg::OP_ADDIU: wv = a + se;
        cpuTypesPkg::OP_SLTI:  wv = {31'd0, $signed(a) < $signed(se)};
        cpuTypesPkg::OP_ANDI:  wv = a & ze;
        cpuTypesPkg::OP_ORI:   wv = a | ze;
        cpuTypesPkg::OP_XORI:  wv = a ^ ze;
        cpuTypesPkg::OP_LUI:   wv = {ins[15:0], 16'h0000};
        cpuTypesPkg::OP_LW:    wv = refMem[ea[9:2]];
        cpuTypesPkg::OP_SW: begin
          we = 1'b0;
          refMem[ea[9:2]] = b;
          expAddr.push_back(ea);
          expData.push_back(b);
        end
        cpuTypesPkg::OP_BEQ: begin
          we = 1'b0;
          if (a == b) begin
            pc = pc + {se[29:0], 2'b00};
          end
        end
        cpuTypesPkg::OP_BNE: begin
          we = 1'b0;
          if (a != b) begin
            pc = pc + {se[29:0], 2'b00};
          end
        end
        cpuTypesPkg::OP_J: begin
          we = 1'b0;
          pc = {pc[31:28], ins[25:0], 2'b00};
        end
        cpuTypesPkg::OP_JAL: begin
          // Link is the address after the JAL
          wr = cpuTypesPkg::LINK_REG;
          wv = pc;
          pc = {pc[31:28], ins[25:0], 2'b00};
        end
        cpuTypesPkg::OP_HALT: return steps;
        default: we = 1'b0;
      endcase
      if (we && wr != 5'd0) begin
        regs[wr] = wv;
      end
    end
    return -1;
  endfunction

  always @(posedge CLK) begin
    if (!refReady) begin
      // Snapshot taken before the DUT can store anything
      for (i = 0; i < 256; i++) begin
        refMem[i] = image[i];
      end
      errorCount = 0;
      storeCount = 0;
      checkDone = 1'b0;
      refSteps = runReference();
      if (refSteps < 0) begin
        $display("ERROR: reference model never reached HALT");
        errorCount++;
      end
      refReady = 1'b1;
    end
    if (!nRST) begin
      if (halt !== 1'b0) begin
        $display("FAILED halt during reset: expected 0, actual %b", halt);
        errorCount++;
      end
      prevPending = 1'b0;
      prevReady = 1'b0;
      afterReset = 1'b1;
    end else begin
      if (afterReset && halt !== 1'b0) begin
        $display("FAILED halt after reset: expected 0, actual %b", halt);
        errorCount++;
      end
      afterReset = 1'b0;
      // Request must hold still while the memory stalls
      if (prevPending && !prevReady && memReq !== prevReq) begin
        $display("ERROR: memory request changed before ready at %0t", $time);
        errorCount++;
      end
      if (halt === 1'b1 && (memReq.ren !== 1'b0 || memReq.wen !== 1'b0)) begin
        $display("ERROR: memory request issued after halt at %0t", $time);
        errorCount++;
      end
      // Completed write
      if (memResp.ready && memReq.wen) begin
        if (storeCount >= expAddr.size()) begin
          $display("ERROR: extra store to %h beyond the reference list", memReq.addr);
          errorCount++;
        end else begin
          if (memReq.addr !== expAddr[storeCount]) begin
            $display("FAILED store %0d address: expected %h, actual %h",
                     storeCount, expAddr[storeCount], memReq.addr);
            errorCount++;
          end
          if (memReq.store !== expData[storeCount]) begin
            $display("FAILED store %0d data: expected %h, actual %h",
                     storeCount, expData[storeCount], memReq.store);
            errorCount++;
          end
        end
        storeCount++;
      end
      if (runDone && !checkDone) begin
        if (storeCount != expAddr.size()) begin
          $display("FAILED store count: expected %0d, actual %0d",
                   expAddr.size(), storeCount);
          errorCount++;
        end
        checkDone = 1'b1;
      end
      prevReq = memReq;
      prevPending = memReq.ren | memReq.wen;
      prevReady = memResp.ready;
    end
  end

endmodule

`default_nettype wire

/* tbCpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tbCpu;

  logic CLK = 1'b0;
  logic nRST;
  cpuTypesPkg::memReq_t memReq;
  cpuTypesPkg::memResp_t memResp;
  logic halt;
  logic runDone;
  logic checkDone;
  logic timedOut;
  logic busy;
  int errorCount;
  int storeCount;
  int cycles;
  int waitLeft;
  int seed;
  int progIdx;
  logic [15:0] slot;
  logic [15:0] marker;
  // Shared word-addressed instruction and data memory
  logic [255:0][31:0] mem;

  always #4 CLK = ~CLK;

  singleCycleCpu dut0 (
    .CLK    (CLK),
    .nRST   (nRST),
    .memReq (memReq),
    .memResp(memResp),
    .halt   (halt)
  );

  tbChecker checker0 (
    .CLK       (CLK),
    .nRST      (nRST),
    .memReq    (memReq),
    .memResp   (memResp),
    .halt      (halt),
    .image     (mem),
    .runDone   (runDone),
    .errorCount(errorCount),
    .storeCount(storeCount),
    .checkDone (checkDone)
  );

  function automatic logic [31:0] rInstr(input logic [5:0] fn, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [4:0] rd,
                                         input logic [4:0] sh);
    return {6'h00, rs, rt, rd, sh, fn};
  endfunction

  function automatic logic [31:0] iInstr(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jInstr(input logic [5:0] op, input logic [25:0] target);
    return {op, target};
  endfunction

  function automatic logic [15:0] randomHalf();
    logic [31:0] r;
    r = $random(seed);
    return r[15:0];
  endfunction

  task automatic emit(input logic [31:0] w);
    mem[progIdx] = w;
    progIdx = progIdx + 1;
  endtask

  // SW rt into the next result slot above the r20 base
  task automatic emitStore(input logic [4:0] rt);
    emit(iInstr(cpuTypesPkg::OP_SW, 5'd20, rt, slot));
    slot = slot + 16'd4;
  endtask

  // Branch over one marker store to a marker store that always runs
  task automatic branchTest(input logic [5:0] op, input logic [4:0] rs, input logic [4:0] rt);
    emit(iInstr(op, rs, rt, 16'd2));
    emit(iInstr(cpuTypesPkg::OP_ADDIU, 5'd0, 5'd25, marker));
    emitStore(5'd25);
    emit(iInstr(cpuTypesPkg::OP_ADDIU, 5'd0, 5'd25, marker + 16'd1));
    emitStore(5'd25);
    marker = marker + 16'd2;
  endtask

  task automatic loadProgram();
    logic [5:0] fnList [10];
    logic [5:0] opList [6];
    int k;
    fnList = '{cpuTypesPkg::FN_ADDU, cpuTypesPkg::FN_SUBU, cpuTypesPkg::FN_AND,
               cpuTypesPkg::FN_OR, cpuTypesPkg::FN_XOR, cpuTypesPkg::FN_NOR,
               cpuTypesPkg::FN_SLT, cpuTypesPkg::FN_SLTU, cpuTypesPkg::FN_SLL,
               cpuTypesPkg::FN_SRL};
    opList = '{cpuTypesPkg::OP_SLTI, cpuTypesPkg::OP_ANDI, cpuTypesPkg::OP_ORI,
               cpuTypesPkg::OP_XORI, cpuTypesPkg::OP_LUI, cpuTypesPkg::OP_ADDIU};
    // Stray fetches hit HALT words tagged with their own index
    for (k = 0; k < 256; k++) begin
      mem[k] = {cpuTypesPkg::OP_HALT, 18'd0, k[7:0]};
    end
    // Random initial data at 0x300 and up
    for (k = 192; k < 256; k++) begin
      mem[k] = $random(seed);
    end
    progIdx = 0;
    slot = 16'h0000;
    marker = 16'h0100;
    emit(iInstr(cpuTypesPkg::OP_ADDIU, 5'd0, 5'd20, 16'h0200));
    emit(iInstr(cpuTypesPkg::OP_LUI, 5'd0, 5'd1, randomHalf()));
    emit(iInstr(cpuTypesPkg::OP_ORI, 5'd1, 5'd1, randomHalf()));
    emit(iInstr(cpuTypesPkg::OP_LUI, 5'd0, 5'd2, randomHalf()));
    emit(iInstr(cpuTypesPkg::OP_ORI, 5'd2, 5'd2, randomHalf()));
    emit(iInstr(cpuTypesPkg::OP_ADDIU, 5'd0, 5'd3, randomHalf()));
    // R-type ops on r1 and r2 with a random shamt
    for (k = 0; k < 10; k++) begin
      emit(rInstr(fnList[k], 5'd1, 5'd2, 5'(4 + k), 5'(randomHalf())));
      emitStore(5'(4 + k));
    end
    // Immediate ops rotate through r1, r2, r3
    for (k = 0; k < 6; k++) begin
      emit(iInstr(opList[k], 5'(1 + k % 3), 5'(14 + k), randomHalf()));
      emitStore(5'(14 + k));
    end
    // Load back earlier results and initial data
    emit(iInstr(cpuTypesPkg::OP_LW, 5'd20, 5'd21, 16'h0000));
    emit(iInstr(cpuTypesPkg::OP_LW, 5'd20, 5'd22, 16'h0004));
    emit(rInstr(cpuTypesPkg::FN_ADDU, 5'd21, 5'd22, 5'd23, 5'd0));
    emitStore(5'd23);
    emit(iInstr(cpuTypesPkg::OP_LW, 5'd20, 5'd24, 16'h0100));
    emitStore(5'd24);
    // Writes to r0 by ALU and by load
    emit(iInstr(cpuTypesPkg::OP_ADDIU, 5'd0, 5'd0, randomHalf()));
    emitStore(5'd0);
    emit(iInstr(cpuTypesPkg::OP_LW, 5'd20, 5'd0, 16'h0008));
    emitStore(5'd0);
    // Branches taken and not taken
    branchTest(cpuTypesPkg::OP_BEQ, 5'd1, 5'd1);
    branchTest(cpuTypesPkg::OP_BEQ, 5'd1, 5'd2);
    branchTest(cpuTypesPkg::OP_BNE, 5'd1, 5'd2);
    branchTest(cpuTypesPkg::OP_BNE, 5'd1, 5'd1);
    branchTest(cpuTypesPkg::OP_BEQ, 5'd0, 5'd0);
    // J over a marker store
    emit(jInstr(cpuTypesPkg::OP_J, 26'(progIdx + 3)));
    emit(iInstr(cpuTypesPkg::OP_ADDIU, 5'd0, 5'd25, 16'h0EEE));
    emitStore(5'd25);
    emit(iInstr(cpuTypesPkg::OP_ADDIU, 5'd0, 5'd25, 16'h0444));
    emitStore(5'd25);
    // Count down from 3 with a backward BNE
    emit(iInstr(cpuTypesPkg::OP_ADDIU, 5'd0, 5'd27, 16'd3));
    emitStore(5'd27);
    emit(iInstr(cpuTypesPkg::OP_ADDIU, 5'd27, 5'd27, 16'hFFFF));
    emit(iInstr(cpuTypesPkg::OP_BNE, 5'd27, 5'd0, 16'hFFFD));
    // Call the subroutine and store the link value before HALT
    emit(jInstr(cpuTypesPkg::OP_JAL, 26'd100));
    emitStore(5'd31);
    emit({cpuTypesPkg::OP_HALT, 26'd0});
    // Subroutine at word 100
    progIdx = 100;
    emit(iInstr(cpuTypesPkg::OP_ADDIU, 5'd0, 5'd26, 16'h0555));
    emitStore(5'd26);
    emit(rInstr(cpuTypesPkg::FN_JR, 5'd31, 5'd0, 5'd0, 5'd0));
  endtask

  // Memory model with 0 to 3 wait states per request
  initial begin
    memResp = '0;
    busy = 1'b0;
    waitLeft = 0;
    forever begin
      @(posedge CLK);
      if (!nRST) begin
        memResp <= '0;
        busy = 1'b0;
      end else if (memResp.ready) begin
        // Access completes at this edge
        memResp.ready <= 1'b0;
        busy = 1'b0;
      end else if (memReq.ren || memReq.wen) begin
        if (!busy) begin
          busy = 1'b1;
          waitLeft = $random(seed) & 3;
        end
        if (waitLeft == 0) begin
          memResp.ready <= 1'b1;
          if (memReq.wen) begin
            mem[memReq.addr[9:2]] <= memReq.store;
          end else begin
            memResp.load <= mem[memReq.addr[9:2]];
          end
        end else begin
          waitLeft = waitLeft - 1;
        end
      end
    end
  end

  initial begin
    seed = 30;
    nRST = 1'b0;
    runDone = 1'b0;
    timedOut = 1'b0;
    loadProgram();
    repeat (4) @(posedge CLK);
    nRST <= 1'b1;
    cycles = 0;
    // Run until halt or the cycle limit
    while (halt !== 1'b1 && cycles < 20000) begin
      @(posedge CLK);
      cycles++;
    end
    if (halt !== 1'b1) begin
      timedOut = 1'b1;
      $display("ERROR: timeout, the CPU did not halt within 20000 cycles");
    end
    // Idle cycles to catch stray requests after halt
    repeat (4) @(posedge CLK);
    runDone <= 1'b1;
    cycles = 0;
    while (checkDone !== 1'b1 && cycles < 10) begin
      @(posedge CLK);
      cycles++;
    end
    if (checkDone !== 1'b1) begin
      timedOut = 1'b1;
      $display("ERROR: checker never finished its final comparison");
    end
    $display("Errors: %0d, stores checked: %0d", errorCount, storeCount);
    if (errorCount == 0 && !timedOut) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
cpuTypesPkg.sv
alu.sv
controlUnit.sv
registerFile.sv
programCounter.sv
requestUnit.sv
datapath.sv
memoryControl.sv
singleCycleCpu.sv
tbChecker.sv
tbCpu.sv
